//--- rtl/armExecPkg.sv
`default_nettype none

package armExecPkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] regAddr_t;

	// data-processing opcodes in instruction order
	typedef enum logic [3:0] {
		AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
		TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
	} aluOp_t;

	// 4'b1111 has no member and is handled as always
	typedef enum logic [3:0] {
		EQ, NE, CS, CC, MI, PL, VS, VC,
		HI, LS, GE, LT, GT, LE, AL
	} condCode_t;

	typedef enum logic [1:0] {LSL, LSR, ASR, ROR} shiftType_t;

	typedef enum logic [1:0] {IDLE, READ, EXEC, DONE} phase_t;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	localparam regAddr_t LINK_REG = 4'd14;
	localparam word_t PC_AHEAD = 32'd8;     // pc reads two words ahead

	localparam int COND_MSB = 31;
	localparam int COND_LSB = 28;
	localparam int IMM_BIT = 25;            // operand 2 is an immediate
	localparam int OPC_MSB = 24;
	localparam int OPC_LSB = 21;
	localparam int S_BIT = 20;
	localparam int RN_MSB = 19;
	localparam int RN_LSB = 16;
	localparam int RD_MSB = 15;
	localparam int RD_LSB = 12;
	localparam int RM_MSB = 3;
	localparam int RM_LSB = 0;
	localparam int ROT_MSB = 11;
	localparam int ROT_LSB = 8;
	localparam int IMM8_MSB = 7;
	localparam int IMM8_LSB = 0;
	localparam int SHAMT_MSB = 11;
	localparam int SHAMT_LSB = 7;
	localparam int SHTYPE_MSB = 6;
	localparam int SHTYPE_LSB = 5;

	// instruction classes
	localparam int DP_CLASS_MSB = 27;
	localparam int DP_CLASS_LSB = 26;
	localparam logic [1:0] DP_CLASS = 2'b00;
	localparam int BR_CLASS_MSB = 27;
	localparam int BR_CLASS_LSB = 25;
	localparam logic [2:0] BR_CLASS = 3'b101;
	localparam int LINK_BIT = 24;
	localparam int OFFSET_MSB = 23;
	localparam int OFFSET_LSB = 0;

endpackage

`default_nettype wire

//--- rtl/condCheck.sv
`timescale 1ns/1ns
`default_nettype none

module condCheck (
	input armExecPkg::condCode_t condCode,
	input armExecPkg::flags_t flags,
	output logic condPass
);

	import armExecPkg::*;

	always_comb begin
		case (condCode)
			EQ: condPass = flags.z;
			NE: condPass = !flags.z;
			CS: condPass = flags.c;          // unsigned higher or same
			CC: condPass = !flags.c;
			MI: condPass = flags.n;
			PL: condPass = !flags.n;
			VS: condPass = flags.v;
			VC: condPass = !flags.v;
			// unsigned compares
			HI: condPass = flags.c && !flags.z;
			LS: condPass = !flags.c || flags.z;
			// signed compares
			GE: condPass = (flags.n == flags.v);
			LT: condPass = (flags.n != flags.v);
			GT: begin
				condPass = !flags.z && (flags.n == flags.v);
			end
			LE: begin
				condPass = flags.z || (flags.n != flags.v);
			end
			default: condPass = 1'b1;        // AL and 4'b1111
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/operandShifter.sv
`timescale 1ns/1ns
`default_nettype none

module operandShifter (
	input logic immSel,
	input logic [3:0] rotate,
	input logic [7:0] immByte,
	input logic [4:0] shiftAmount,
	input armExecPkg::shiftType_t shiftType,
	input armExecPkg::word_t regValue,
	input logic carryIn,
	output armExecPkg::word_t operand,
	output logic carryOut
);

	import armExecPkg::*;

	word_t immWord;
	word_t immRot;
	logic [4:0] rotAmount;
	logic [4:0] lowIdx;
	logic [4:0] lslIdx;
	word_t shifted;
	logic shiftCarry;

	assign immWord = {24'd0, immByte};
	assign rotAmount = {rotate, 1'b0};   // field counts in bit pairs
	// shift by 32 gives zero, so rotate 0 leaves the byte alone
	assign immRot = (immWord >> rotAmount) | (immWord << (6'd32 - {1'b0, rotAmount}));

	assign lowIdx = shiftAmount - 5'd1;  // last bit shifted out to the right
	assign lslIdx = 5'd0 - shiftAmount;  // 32 - amount, mod 32

	always_comb begin
		shifted = regValue;
		shiftCarry = carryIn;
		case (shiftType)
			LSL: begin
				if (shiftAmount != 5'd0) begin
					shifted = regValue << shiftAmount;
					shiftCarry = regValue[lslIdx];
				end
			end
			LSR: begin
				shifted = (shiftAmount == 5'd0) ? '0 : regValue >> shiftAmount;
				shiftCarry = (shiftAmount == 5'd0) ? regValue[31] : regValue[lowIdx];
			end
			ASR: begin
				// amount 0 encodes a shift by 32
				if (shiftAmount == 5'd0) begin
					shifted = {32{regValue[31]}};
					shiftCarry = regValue[31];
				end else begin
					shifted = word_t'($signed(regValue) >>> shiftAmount);
					shiftCarry = regValue[lowIdx];
				end
			end
			default: begin
				if (shiftAmount != 5'd0) begin
					shifted = (regValue >> shiftAmount) | (regValue << lslIdx);
					shiftCarry = regValue[lowIdx];
				end
			end
		endcase
	end

	assign operand = immSel ? immRot : shifted;
	assign carryOut = immSel ? ((rotate == 4'd0) ? carryIn : immRot[31]) : shiftCarry;

endmodule

`default_nettype wire

//--- rtl/execAlu.sv
`timescale 1ns/1ns
`default_nettype none

module execAlu (
	input armExecPkg::aluOp_t aluOp,
	input armExecPkg::word_t operandA,
	input armExecPkg::word_t operandB,
	input armExecPkg::flags_t flagsIn,
	input logic shifterCarry,
	output armExecPkg::word_t result,
	output armExecPkg::flags_t flagsOut,
	output logic writesResult
);

	import armExecPkg::*;

	word_t addA;
	word_t addB;
	logic addCin;
	logic [32:0] sum;
	logic addOvf;
	logic isLogical;

	// one adder serves every arithmetic op, subtraction as a + ~b + 1
	always_comb begin
		addA = operandA;
		addB = operandB;
		addCin = 1'b0;
		case (aluOp)
			SUB, CMP: begin
				addB = ~operandB;
				addCin = 1'b1;
			end
			RSB: begin
				addA = operandB;
				addB = ~operandA;
				addCin = 1'b1;
			end
			ADC: addCin = flagsIn.c;
			SBC: begin
				addB = ~operandB;
				addCin = flagsIn.c;         // borrow is the inverted carry
			end
			RSC: begin
				addA = operandB;
				addB = ~operandA;
				addCin = flagsIn.c;
			end
			default: addCin = 1'b0;        // ADD, CMN
		endcase
	end

	assign sum = {1'b0, addA} + {1'b0, addB} + {32'd0, addCin};
	assign addOvf = (addA[31] == addB[31]) && (sum[31] != addA[31]);

	always_comb begin
		isLogical = 1'b1;
		case (aluOp)
			AND, TST: result = operandA & operandB;
			EOR, TEQ: result = operandA ^ operandB;
			ORR: result = operandA | operandB;
			MOV: result = operandB;
			BIC: result = operandA & ~operandB;
			MVN: result = ~operandB;
			default: begin
				result = sum[31:0];
				isLogical = 1'b0;
			end
		endcase
	end

	assign flagsOut.n = result[31];
	assign flagsOut.z = (result == '0);
	assign flagsOut.c = isLogical ? shifterCarry : sum[32];
	assign flagsOut.v = isLogical ? flagsIn.v : addOvf;   // logical ops keep V

	assign writesResult = !(aluOp inside {TST, TEQ, CMP, CMN});

endmodule

`default_nettype wire

//--- rtl/execSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module execSequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input armExecPkg::word_t instr,
	input armExecPkg::word_t pc,
	output logic busy,
	output logic done,
	output logic regRdEn,
	output armExecPkg::regAddr_t regRdAddrA,
	output armExecPkg::regAddr_t regRdAddrB,
	input armExecPkg::word_t regRdDataB,
	output logic regWrEn,
	output armExecPkg::regAddr_t regWrAddr,
	output armExecPkg::word_t regWrData,
	output logic branchTaken,
	output armExecPkg::word_t branchTarget,
	output armExecPkg::flags_t flags,
	output armExecPkg::condCode_t condCode,
	input logic condPass,
	output logic shiftImm,
	output logic [3:0] rotate,
	output logic [7:0] immByte,
	output logic [4:0] shiftAmount,
	output armExecPkg::shiftType_t shiftType,
	output armExecPkg::word_t shiftValue,
	input logic shifterCarry,
	output logic aluShiftCarry,
	output armExecPkg::aluOp_t aluOp,
	input armExecPkg::word_t aluResult,
	input armExecPkg::flags_t aluFlags,
	input logic aluWrites
);

	import armExecPkg::*;

	phase_t phase;
	word_t instrQ;
	word_t pcQ;
	logic accept;
	logic isDataProc;
	logic isBranch;
	logic inExec;
	word_t offsetExt;

	assign accept = start && (phase == IDLE);   // start while busy is dropped

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= IDLE;
		end else begin
			case (phase)
				IDLE: phase <= accept ? READ : IDLE;
				READ: phase <= EXEC;
				EXEC: phase <= DONE;
				default: phase <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			instrQ <= instr;
			pcQ <= pc;
		end
	end

	assign isDataProc = (instrQ[DP_CLASS_MSB:DP_CLASS_LSB] == DP_CLASS);
	assign isBranch = (instrQ[BR_CLASS_MSB:BR_CLASS_LSB] == BR_CLASS);
	assign inExec = (phase == EXEC) && condPass;

	// only S-bit data processing that passes its condition touches the flags
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (inExec && isDataProc && instrQ[S_BIT]) begin
			flags <= aluFlags;
		end
	end

	assign busy = (phase != IDLE);
	assign done = (phase == DONE);

	// register file answers one cycle later, in EXEC
	assign regRdEn = (phase == READ) && isDataProc;
	assign regRdAddrA = instrQ[RN_MSB:RN_LSB];
	assign regRdAddrB = instrQ[RM_MSB:RM_LSB];

	assign condCode = condCode_t'(instrQ[COND_MSB:COND_LSB]);
	assign aluOp = aluOp_t'(instrQ[OPC_MSB:OPC_LSB]);

	// operand 2 fields for the shifter
	assign shiftImm = instrQ[IMM_BIT];
	assign rotate = instrQ[ROT_MSB:ROT_LSB];
	assign immByte = instrQ[IMM8_MSB:IMM8_LSB];
	assign shiftAmount = instrQ[SHAMT_MSB:SHAMT_LSB];
	assign shiftType = shiftType_t'(instrQ[SHTYPE_MSB:SHTYPE_LSB]);
	assign shiftValue = shiftImm ? '0 : regRdDataB;   // quiet for immediates
	assign aluShiftCarry = shifterCarry;

	// branch offset is in words
	assign offsetExt = {{8{instrQ[OFFSET_MSB]}}, instrQ[OFFSET_MSB:OFFSET_LSB]};
	assign branchTarget = pcQ + PC_AHEAD + {offsetExt[29:0], 2'b00};
	assign branchTaken = inExec && isBranch;

	// BL links to the instruction after the branch
	assign regWrEn = inExec && (isDataProc ? aluWrites : (isBranch && instrQ[LINK_BIT]));
	assign regWrAddr = isBranch ? LINK_REG : instrQ[RD_MSB:RD_LSB];
	assign regWrData = isBranch ? pcQ + 32'd4 : aluResult;

endmodule

`default_nettype wire

//--- rtl/execCore.sv
`timescale 1ns/1ns
`default_nettype none

module execCore (
	input logic clk,
	input logic rst,
	input logic start,
	input armExecPkg::word_t instr,
	input armExecPkg::word_t pc,
	output logic busy,
	output logic done,
	output logic regRdEn,
	output armExecPkg::regAddr_t regRdAddrA,
	output armExecPkg::regAddr_t regRdAddrB,
	input armExecPkg::word_t regRdDataA,
	input armExecPkg::word_t regRdDataB,
	output logic regWrEn,
	output armExecPkg::regAddr_t regWrAddr,
	output armExecPkg::word_t regWrData,
	output logic branchTaken,
	output armExecPkg::word_t branchTarget,
	output armExecPkg::flags_t flags
);

	import armExecPkg::*;

	condCode_t condCode;
	logic condPass;
	logic shiftImm;
	logic [3:0] rotate;
	logic [7:0] immByte;
	logic [4:0] shiftAmount;
	shiftType_t shiftType;
	word_t shiftValue;
	word_t operand2;
	logic shifterCarry;
	logic aluShiftCarry;
	aluOp_t aluOp;
	word_t aluResult;
	flags_t aluFlags;
	logic aluWrites;

	execSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.instr(instr),
		.pc(pc),
		.busy(busy),
		.done(done),
		.regRdEn(regRdEn),
		.regRdAddrA(regRdAddrA),
		.regRdAddrB(regRdAddrB),
		.regRdDataB(regRdDataB),
		.regWrEn(regWrEn),
		.regWrAddr(regWrAddr),
		.regWrData(regWrData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.flags(flags),
		.condCode(condCode),
		.condPass(condPass),
		.shiftImm(shiftImm),
		.rotate(rotate),
		.immByte(immByte),
		.shiftAmount(shiftAmount),
		.shiftType(shiftType),
		.shiftValue(shiftValue),
		.shifterCarry(shifterCarry),
		.aluShiftCarry(aluShiftCarry),
		.aluOp(aluOp),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.aluWrites(aluWrites)
	);

	condCheck condition (
		.condCode(condCode),
		.flags(flags),
		.condPass(condPass)
	);

	operandShifter shifter (
		.immSel(shiftImm),
		.rotate(rotate),
		.immByte(immByte),
		.shiftAmount(shiftAmount),
		.shiftType(shiftType),
		.regValue(shiftValue),
		.carryIn(flags.c),              // stored carry feeds zero shifts
		.operand(operand2),
		.carryOut(shifterCarry)
	);

	execAlu alu (
		.aluOp(aluOp),
		.operandA(regRdDataA),          // rn straight from port A
		.operandB(operand2),
		.flagsIn(flags),
		.shifterCarry(aluShiftCarry),
		.result(aluResult),
		.flagsOut(aluFlags),
		.writesResult(aluWrites)
	);

endmodule

`default_nettype wire

//--- verification/execCore_assert.sv
`timescale 1ns/1ns
`default_nettype none

module execCore_assert (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic regRdEn,
	input logic regWrEn,
	input logic branchTaken
);

	// done is a single-cycle pulse
	doneOneCycle: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else $error("done held for more than one cycle");

	writeWhileBusy: assert property (@(posedge clk) disable iff (rst)
		regWrEn |-> busy)
		else $error("register write outside an instruction");

	branchWhileBusy: assert property (@(posedge clk) disable iff (rst)
		branchTaken |-> busy)
		else $error("branch reported outside an instruction");

	// read and write phases never overlap
	noReadWrite: assert property (@(posedge clk) disable iff (rst)
		!(regRdEn && regWrEn))
		else $error("register read and write in the same cycle");

endmodule

`default_nettype wire

//--- verification/execCore_tb.sv
`timescale 1ns/1ns
`default_nettype none

module execCore_tb;

	import armExecPkg::*;

	localparam int MAX_TESTS = 64;

	logic clk;
	logic rst;
	logic start;
	word_t instr;
	word_t pc;
	logic busy;
	logic done;
	logic regRdEn;
	regAddr_t regRdAddrA;
	regAddr_t regRdAddrB;
	word_t regRdDataA;
	word_t regRdDataB;
	logic regWrEn;
	regAddr_t regWrAddr;
	word_t regWrData;
	logic branchTaken;
	word_t branchTarget;
	flags_t flags;

	word_t regs [16];
	int readCount;
	int numTests;
	bit testsLoaded;
	string curName;

	// one row of the data file per entry
	string tName [MAX_TESTS];
	word_t tInstr [MAX_TESTS];
	word_t tPc [MAX_TESTS];
	word_t tWrEn [MAX_TESTS];
	word_t tWrAddr [MAX_TESTS];
	word_t tWrData [MAX_TESTS];
	word_t tBrTaken [MAX_TESTS];
	word_t tBrTarget [MAX_TESTS];
	word_t tFlags [MAX_TESTS];

	execCore execCore_i (.*);

	bind execCore execCore_assert execCore_assert_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = !clk;
	end

	// register file model answering one cycle after regRdEn
	always @(posedge clk) begin
		if (regRdEn) begin
			regRdDataA <= regs[regRdAddrA];
			regRdDataB <= regs[regRdAddrB];
			readCount <= readCount + 1;
		end
		if (regWrEn) begin
			regs[regWrAddr] <= regWrData;
		end
	end

	task automatic compare(input string what, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("mismatch in %0s (%0s): expected %08h, actual %08h",
				curName, what, expected, actual);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic loadTests();
		int fd;
		int count;
		string line;
		string nm;
		word_t v [8];
		fd = $fopen("verification/execCore_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/execCore_input.txt");
			$display("Testbench failed");
			$fatal(1);
		end
		numTests = 0;
		while (!$feof(fd) && numTests < MAX_TESTS) begin
			line = "";
			void'($fgets(line, fd));
			count = $sscanf(line, "%s %h %h %h %h %h %h %h %h", nm,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
			if (count == 9) begin   // comment and blank lines fall through
				tName[numTests] = nm;
				tInstr[numTests] = v[0];
				tPc[numTests] = v[1];
				tWrEn[numTests] = v[2];
				tWrAddr[numTests] = v[3];
				tWrData[numTests] = v[4];
				tBrTaken[numTests] = v[5];
				tBrTarget[numTests] = v[6];
				tFlags[numTests] = v[7];
				numTests++;
			end
		end
		$fclose(fd);
		if (numTests == 0) begin
			$display("no test rows found in verification/execCore_input.txt");
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic runTest(input int idx);
		int readsBefore;
		int writes;
		int branches;
		word_t seenAddr;
		word_t seenData;
		word_t seenTarget;
		word_t expReads;
		curName = tName[idx];
		writes = 0;
		branches = 0;
		seenAddr = '0;
		seenData = '0;
		seenTarget = '0;
		expReads = (tInstr[idx][27:26] == 2'b00) ? 32'd1 : 32'd0;   // data processing only
		@(posedge clk);
		#1;
		start = 1'b1;
		instr = tInstr[idx];
		pc = tPc[idx];
		readsBefore = readCount;
		@(posedge clk);   // accept edge is cycle 0
		#1;
		instr = 32'hE3A0E0AA;   // mov r14 while busy is dropped
		pc = 32'hDEAD0000;
		for (int c = 1; c <= 3; c++) begin
			@(negedge clk);
			compare("busy", 32'd1, {31'd0, busy});
			compare("done", (c == 3) ? 32'd1 : 32'd0, {31'd0, done});
			if (regWrEn) begin
				compare("write cycle", 32'd2, c);
				writes++;
				seenAddr = {28'd0, regWrAddr};
				seenData = regWrData;
			end
			if (branchTaken) begin
				compare("branch cycle", 32'd2, c);
				branches++;
				seenTarget = branchTarget;
			end
			@(posedge clk);
			#1;
			if (c == 2) begin
				start = 1'b0;
			end
		end
		compare("busy after done", 32'd0, {31'd0, busy});
		compare("reads", expReads, readCount - readsBefore);
		compare("write enable", tWrEn[idx], writes);
		if (tWrEn[idx] != 0) begin
			compare("write address", tWrAddr[idx], seenAddr);
			compare("write data", tWrData[idx], seenData);
		end
		compare("branch taken", tBrTaken[idx], branches);
		if (tBrTaken[idx] != 0) begin
			compare("branch target", tBrTarget[idx], seenTarget);
		end
		compare("flags", tFlags[idx], {28'd0, flags});
	endtask

	// watchdog sized from the number of rows
	initial begin
		wait (testsLoaded);
		#((numTests * 10 + 3 + 5) * 10);
		$display("run did not finish in time, DUT appears hung");
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin
		int gap;
		void'($urandom(32'hf7a9));
		start = 1'b0;
		instr = '0;
		pc = '0;
		regRdDataA = '0;
		regRdDataB = '0;
		readCount = 0;
		numTests = 0;
		for (int i = 0; i < 16; i++) begin
			regs[i] = i * 32'h01010101;
		end
		loadTests();
		testsLoaded = 1'b1;
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < numTests; i++) begin
			gap = $urandom_range(0, 3);
			repeat (gap) @(posedge clk);
			runTest(i);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/execCore_input.txt
# name instr pc wrEn wrAddr wrData brTaken brTarget flags(NZCV)
# all values hex, registers start as i * 01010101
add_r4_imm      E2844001 00000100 1 4 04040405 0 00000000 0
sub_r13_imm     E24BD010 00000104 1 D 0B0B0AFB 0 00000000 0
add_reg         E0815002 00000108 1 5 03030303 0 00000000 0
eor_lsl4        E0236201 0000010C 1 6 13131313 0 00000000 0
orr_rotimm      E38074FF 00000110 1 7 FF000000 0 00000000 0
movs_lsr8       E1B08427 00000114 1 8 00FF0000 0 00000000 0
subs_zero       E0549004 00000118 1 9 00000000 0 00000000 6
addne_skip      1281A001 0000011C 0 0 00000000 0 00000000 6
adc_carry       E0A1A002 00000120 1 A 03030304 0 00000000 6
cmp_neg         E1520003 00000124 0 0 00000000 0 00000000 8
sbc_borrow      E0C6B001 00000128 1 B 12121211 0 00000000 8
movs_asr25      E1B0CCC7 0000012C 1 C FFFFFFFF 0 00000000 A
bic_ror8        E1CCD461 00000130 1 D FEFEFEFE 0 00000000 A
mvn_imm         E3E030FF 00000134 1 3 FFFFFF00 0 00000000 A
rsb_rotimm      E2612C01 00000138 1 2 FEFEFFFF 0 00000000 A
ands_rotcarry   E21304F0 0000013C 1 0 F0000000 0 00000000 A
teq_zero        E1300000 00000140 0 0 00000000 0 00000000 6
bne_skip        1A000010 00001000 0 0 00000000 0 00000000 6
b_fwd           EA0008AE 00008000 0 0 00000000 1 0000A2C0 6
bl_link         EB00382C 00010000 1 E 00010004 1 0001E0B8 6
b_back          EAFFFFFE 00002000 0 0 00000000 1 00002000 6
cmn_carry       E171000C 00000144 0 0 00000000 0 00000000 2
movge_pass      A3A05001 00000148 1 5 00000001 0 00000000 2
movlt_skip      B3A05002 0000014C 0 0 00000000 0 00000000 2

//--- compile.f
rtl/armExecPkg.sv
rtl/condCheck.sv
rtl/operandShifter.sv
rtl/execAlu.sv
rtl/execSequencer.sv
rtl/execCore.sv
verification/execCore_assert.sv
verification/execCore_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module execCore_tb \
		-f compile.f -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
